// File: Makefile
# Verilator build and run for the packet queue scheduler

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module pq_tb -f build.f -Mdir $(OBJ_DIR) -o pq_tb
	./$(OBJ_DIR)/pq_tb

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
rtl/pq_pkg.sv
rtl/pq_enqueue.sv
rtl/pq_desc_mem.sv
rtl/pq_sched.sv
rtl/pq_dequeue_engine.sv
rtl/pq_top.sv
dv/pq_tb.sv

// File: dv/pq_tb.sv
/* Packet queue scheduler testbench that drives a descriptor table through the
   DUT and checks priority order, segmentation and credit flow against a model */

`default_nettype none

module pq_tb;

    import pq_pkg::*;

    localparam int enq_fifo_depth = 4;
    localparam int egr_credit_max = 16;
    localparam int num_rows       = 24;
    localparam int cycle_limit    = 40 * num_rows + 200;

    // Length zero in a row means a random length
    typedef struct packed {
        queue_id_t queue;
        blen_t     blen;
        logic      phase;
    } row_t;

    row_t stim_table [num_rows] = '{
        // Phase 0 covers priority order and length corners
        '{4'd0,  11'd64,   1'b0}, '{4'd1,  11'd65,  1'b0}, '{4'd3,  11'd1,   1'b0},
        '{4'd2,  11'd128,  1'b0}, '{4'd3,  11'd1500, 1'b0}, '{4'd0,  11'd63,  1'b0},
        '{4'd5,  11'd200,  1'b0}, '{4'd7,  11'd129, 1'b0}, '{4'd4,  11'd64,  1'b0},
        '{4'd10, 11'd1,    1'b0}, '{4'd11, 11'd0,   1'b0}, '{4'd15, 11'd0,   1'b0},
        // Phase 1 has random lengths under random credit
        '{4'd0,  11'd0,    1'b1}, '{4'd2,  11'd0,   1'b1}, '{4'd3,  11'd0,   1'b1},
        '{4'd6,  11'd0,    1'b1}, '{4'd6,  11'd0,   1'b1}, '{4'd9,  11'd0,   1'b1},
        '{4'd8,  11'd0,    1'b1}, '{4'd13, 11'd0,   1'b1}, '{4'd12, 11'd0,   1'b1},
        '{4'd14, 11'd0,    1'b1}, '{4'd3,  11'd0,   1'b1}, '{4'd1,  11'd1500, 1'b1}
    };

    logic        core_clk_ifc;
    logic        rst;
    enq_desc_t   enq_in;
    logic        enq_link_credit;
    deq_req_t    slot_free;
    credit_vec_t egr_credit;
    egr_word_t   egr_out;

    // Producer side state
    logic        quiet;
    logic [31:0] rng_state;
    int          link_used;
    int          rows_sent;
    int          slot_used  [num_queues];
    int          model_len  [num_queues][queue_depth];
    int          model_push [num_queues];
    int          need_words [num_ports];

    // Monitor side state
    int          cycle_cnt;
    int          link_returned;
    int          slot_returned [num_queues];
    int          model_pop     [num_queues];
    int          finished      [num_queues];
    int          granted       [num_ports];
    int          words         [num_ports];
    int          pkts_done;
    int          pkt_queue;
    int          pkt_len;
    int          pkt_words;
    int          pkt_word;

    pq_top #(
        .enq_fifo_depth  (enq_fifo_depth),
        .egr_credit_max  (egr_credit_max)
    ) i_pq_top (
        .clk             (core_clk_ifc),
        .rst             (rst),
        .enq_in          (enq_in),
        .enq_link_credit (enq_link_credit),
        .slot_free       (slot_free),
        .egr_credit      (egr_credit),
        .egr_out         (egr_out)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #2 core_clk_ifc = ~core_clk_ifc;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0d, expected %0d", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic bit drained();
        if (pkts_done != rows_sent) begin
            return 1'b0;
        end
        for (int q = 0; q < num_queues; q++) begin
            if (slot_returned[q] != slot_used[q]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Monitor

    task automatic free_slot(input int q);
        check_eq(32'(finished[q] > slot_returned[q]), 32'd1, "slot_free of unfinished packet");
        slot_returned[q]++;
    endtask

    task automatic check_word();
        int q;
        int p;
        int top;
        int exp_bytes;
        bit exp_last;
        q = int'(egr_out.queue);
        p = int'(egr_out.port);
        check_eq(32'(p), 32'(q / queues_per_port), "word port");
        words[p]++;
        check_eq(32'(words[p] <= granted[p]), 32'd1, "words within granted credit");
        if (pkt_word == pkt_words) begin
            // New packet comes from the highest non-empty priority of its port
            top = num_queues;
            for (int pr = 0; pr < queues_per_port; pr++) begin
                if (model_push[p*queues_per_port + pr] > model_pop[p*queues_per_port + pr]) begin
                    top = p*queues_per_port + pr;
                end
            end
            check_eq(32'(q), 32'(top), "packet queue by priority");
            pkt_queue = q;
            pkt_len   = model_len[q][model_pop[q] % queue_depth];
            pkt_words = (pkt_len + data_bytes - 1) / data_bytes;
            pkt_word  = 0;
            model_pop[q]++;
        end
        check_eq(32'(q), 32'(pkt_queue), "word queue inside packet");
        // Full words first, the final word carries what is left
        exp_last  = (pkt_word == pkt_words - 1);
        exp_bytes = exp_last ? pkt_len - data_bytes * (pkt_words - 1) : data_bytes;
        check_eq(32'(egr_out.bytes), 32'(exp_bytes), "word byte count");
        check_eq(32'(egr_out.last), 32'(exp_last), "last flag");
        pkt_word++;
        if (exp_last) begin
            finished[q]++;
            pkts_done++;
        end
    endtask

    always @(posedge core_clk_ifc) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout, traffic did not drain within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
        // Registers settle on the first reset edge
        if (quiet && cycle_cnt > 2) begin
            check_eq(32'(egr_out.valid), 32'd0, "egr_out.valid before traffic");
            check_eq(32'(slot_free.valid), 32'd0, "slot_free.valid before traffic");
            check_eq(32'(enq_link_credit), 32'd0, "link credit before traffic");
        end
        for (int p = 0; p < num_ports; p++) begin
            granted[p] += int'(egr_credit[p]);
        end
        if (enq_link_credit) begin
            link_returned++;
        end
        if (slot_free.valid) begin
            free_slot(int'(slot_free.queue));
        end
        if (egr_out.valid) begin
            check_word();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Producer and credit source

    task automatic send_desc(input int q, input int len);
        int blen;
        blen = len;
        while (link_used - link_returned == enq_fifo_depth ||
               slot_used[q] - slot_returned[q] == queue_depth) begin
            @(negedge core_clk_ifc);
        end
        if (blen == 0) begin
            rng_state = xorshift(rng_state);
            blen = 1 + int'(rng_state % 32'(max_blen));
        end
        model_len[q][model_push[q] % queue_depth] = blen;
        model_push[q]++;
        need_words[q / queues_per_port] += (blen + data_bytes - 1) / data_bytes;
        link_used++;
        slot_used[q]++;
        rows_sent++;
        enq_in = '{valid: 1'b1, queue: queue_id_t'(q), blen: blen_t'(blen)};
        @(negedge core_clk_ifc);
        enq_in = '0;
    endtask

    task automatic grant_credit(input int ph);
        credit_vec_t grant;
        rng_state = xorshift(rng_state);
        for (int p = 0; p < num_ports; p++) begin
            // Exact total per port while the DUT counter stays below its ceiling
            grant[p] = (granted[p] < need_words[p]) &&
                       (granted[p] - words[p] < egr_credit_max) &&
                       (ph == 0 || rng_state[p*3] == 1'b1);
        end
        egr_credit = grant;
    endtask

    task automatic run_phase(input int ph);
        for (int i = 0; i < num_rows; i++) begin
            if (int'(stim_table[i].phase) == ph) begin
                send_desc(int'(stim_table[i].queue), int'(stim_table[i].blen));
            end
        end
        // Every descriptor written before the first egress credit
        while (link_used != link_returned) begin
            @(negedge core_clk_ifc);
        end
        @(negedge core_clk_ifc);
        while (!drained()) begin
            grant_credit(ph);
            @(negedge core_clk_ifc);
        end
        egr_credit = '0;
    endtask

    initial begin
        rst        = 1'b1;
        enq_in     = '0;
        egr_credit = '0;
        quiet      = 1'b1;
        rng_state  = 32'd11249;
        link_used  = 0;
        rows_sent  = 0;
        for (int q = 0; q < num_queues; q++) begin
            slot_used[q]  = 0;
            model_push[q] = 0;
        end
        for (int p = 0; p < num_ports; p++) begin
            need_words[p] = 0;
        end
        repeat (10) @(negedge core_clk_ifc);
        rst = 1'b0;
        repeat (5) @(negedge core_clk_ifc);
        quiet = 1'b0;

        run_phase(0);
        run_phase(1);

        check_eq(32'(link_returned), 32'(num_rows), "link credits returned");
        check_eq(32'(i_pq_top.queue_empty), 32'((1 << num_queues) - 1), "all queues empty");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/pq_dequeue_engine.sv
/* Dequeue engine, fetches the head descriptor of the picked queue and cuts
   the packet into egress words under port credit, then pops it */

`default_nettype none

module pq_dequeue_engine (
    input  logic                clk,
    input  logic                rst,
    input  pq_pkg::deq_req_t    deq_req,
    output logic                busy,
    output pq_pkg::mem_req_t    deq_mem_req,
    input  logic                deq_mem_grant,
    input  pq_pkg::mem_rsp_t    mem_rsp,
    input  pq_pkg::credit_vec_t credit_avail,
    output pq_pkg::deq_req_t    word_sent,
    output pq_pkg::egr_word_t   egr_out
);

    import pq_pkg::*;

    deq_state_t  state;
    queue_id_t   cur_queue;
    port_id_t    cur_port;
    blen_t       rem_blen;
    logic        pop_req;
    logic        word_fire;
    logic        word_last;
    word_bytes_t word_bytes;

    logic        out_valid;
    port_id_t    out_port;
    queue_id_t   out_queue;
    word_bytes_t out_bytes;
    logic        out_last;

    assign busy     = (state != idle);
    assign cur_port = queue_port(cur_queue);

    // Remainder at zero while in send means all words are out
    assign pop_req   = (state == send) && (rem_blen == '0);
    assign word_fire = (state == send) && (rem_blen != '0) && credit_avail[cur_port];
    assign word_last = (rem_blen <= blen_t'(data_bytes));
    assign word_bytes = word_last ? word_bytes_t'(rem_blen) : word_bytes_t'(data_bytes);

    assign deq_mem_req = '{
        valid: (state == read) || pop_req,
        write: pop_req,
        queue: cur_queue,
        blen:  '0
    };

    assign word_sent = '{valid: word_fire, queue: cur_queue};

    ////////////////////////////////////////////////////////////////////////////
    // FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            rem_blen <= '0;
        end else begin
            case (state)
                idle: begin
                    if (deq_req.valid) begin
                        state <= read;
                    end
                end
                read: begin
                    if (deq_mem_grant) begin
                        state <= wait_rsp;
                    end
                end
                wait_rsp: begin
                    if (mem_rsp.valid) begin
                        rem_blen <= mem_rsp.blen;
                        state    <= send;
                    end
                end
                send: begin
                    if (word_fire) begin
                        rem_blen <= rem_blen - blen_t'(word_bytes);
                    end else if (pop_req && deq_mem_grant) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && deq_req.valid) begin
            cur_queue <= deq_req.queue;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Egress word register

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= word_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (word_fire) begin
            out_port  <= cur_port;
            out_queue <= cur_queue;
            out_bytes <= word_bytes;
            out_last  <= word_last;
        end
    end

    assign egr_out = '{
        valid: out_valid,
        port:  out_port,
        queue: out_queue,
        bytes: out_bytes,
        last:  out_last
    };

endmodule

`default_nettype wire

// File: rtl/pq_desc_mem.sv
/* Shared single-port descriptor memory with round-robin access arbitration,
   per-queue head/tail pointers, occupancy counts and empty flags */

`default_nettype none

module pq_desc_mem (
    input  logic                           clk,
    input  logic                           rst,
    input  pq_pkg::mem_req_t               enq_mem_req,
    output logic                           enq_mem_grant,
    input  pq_pkg::mem_req_t               deq_mem_req,
    output logic                           deq_mem_grant,
    output pq_pkg::mem_rsp_t               mem_rsp,
    output logic [pq_pkg::num_queues-1:0]  queue_empty,
    output pq_pkg::deq_req_t               slot_free
);

    import pq_pkg::*;

    localparam int occ_w  = $clog2(queue_depth + 1);
    localparam int addr_w = queue_w + slot_w;

    blen_t desc_ram [num_queues * queue_depth];

    logic [slot_w-1:0] head_ptr [num_queues];
    logic [slot_w-1:0] tail_ptr [num_queues];
    logic [occ_w-1:0]  occ      [num_queues];

    logic              prefer_deq;
    mem_req_t          sel_req;
    logic              granted;
    logic              do_write;
    logic              do_read;
    logic              do_pop;
    logic [addr_w-1:0] wr_addr;
    logic [addr_w-1:0] rd_addr;

    logic              rsp_valid;
    blen_t             rsp_blen;
    logic              free_valid;
    queue_id_t         free_queue;

    ////////////////////////////////////////////////////////////////////////////
    // Arbiter

    // Both requesting: whoever was not served last time wins
    assign enq_mem_grant = enq_mem_req.valid && !(deq_mem_req.valid && prefer_deq);
    assign deq_mem_grant = deq_mem_req.valid && !(enq_mem_req.valid && !prefer_deq);

    assign sel_req = enq_mem_grant ? enq_mem_req : deq_mem_req;
    assign granted = enq_mem_grant || deq_mem_grant;

    assign do_write = granted && sel_req.write && (sel_req.blen != '0);
    assign do_pop   = granted && sel_req.write && (sel_req.blen == '0);
    assign do_read  = granted && !sel_req.write;

    assign wr_addr = {sel_req.queue, tail_ptr[sel_req.queue]};
    assign rd_addr = {sel_req.queue, head_ptr[sel_req.queue]};

    ////////////////////////////////////////////////////////////////////////////
    // Storage and pointers

    always_ff @(posedge clk) begin
        if (do_write) begin
            desc_ram[wr_addr] <= sel_req.blen;
        end
        if (do_read) begin
            rsp_blen <= desc_ram[rd_addr];
        end
        if (do_pop) begin
            free_queue <= sel_req.queue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int q = 0; q < num_queues; q++) begin
                head_ptr[q] <= '0;
                tail_ptr[q] <= '0;
                occ[q]      <= '0;
            end
            prefer_deq <= 1'b0;
            rsp_valid  <= 1'b0;
            free_valid <= 1'b0;
        end else begin
            if (enq_mem_grant) begin
                prefer_deq <= 1'b1;
            end else if (deq_mem_grant) begin
                prefer_deq <= 1'b0;
            end

            // One grant per cycle, so write and pop never collide
            if (do_write) begin
                tail_ptr[sel_req.queue] <= tail_ptr[sel_req.queue] + 1'b1;
                occ[sel_req.queue]      <= occ[sel_req.queue] + 1'b1;
            end
            if (do_pop) begin
                head_ptr[sel_req.queue] <= head_ptr[sel_req.queue] + 1'b1;
                occ[sel_req.queue]      <= occ[sel_req.queue] - 1'b1;
            end

            rsp_valid  <= do_read;
            free_valid <= do_pop;
        end
    end

    always_comb begin
        for (int q = 0; q < num_queues; q++) begin
            queue_empty[q] = (occ[q] == '0);
        end
    end

    assign mem_rsp   = '{valid: rsp_valid, blen: rsp_blen};
    assign slot_free = '{valid: free_valid, queue: free_queue};

endmodule

`default_nettype wire

// File: rtl/pq_enqueue.sv
/* Enqueue buffer, holds producer descriptors and feeds them to the descriptor
   memory as write requests, returning one link credit per entry written */

`default_nettype none

module pq_enqueue #(
    parameter int enq_fifo_depth = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  pq_pkg::enq_desc_t enq_in,
    output pq_pkg::mem_req_t  enq_mem_req,
    input  logic              enq_mem_grant,
    output logic              enq_link_credit
);

    import pq_pkg::*;

    localparam int ptr_w = (enq_fifo_depth > 1) ? $clog2(enq_fifo_depth) : 1;
    localparam int cnt_w = $clog2(enq_fifo_depth + 1);

    queue_id_t fifo_queue [enq_fifo_depth];
    blen_t     fifo_blen  [enq_fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    // Producer credits keep the FIFO from overflowing
    assign push = enq_in.valid;
    assign pop  = enq_mem_req.valid && enq_mem_grant;

    assign enq_mem_req = '{
        valid: (count != '0),
        write: 1'b1,
        queue: fifo_queue[rd_ptr],
        blen:  fifo_blen[rd_ptr]
    };

    // Credit goes back as the head entry leaves
    assign enq_link_credit = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_queue[wr_ptr] <= enq_in.queue;
            fifo_blen[wr_ptr]  <= enq_in.blen;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(enq_fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(enq_fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pq_pkg.sv
/* Packet queue scheduler shared sizes, descriptor structs and engine states */

`default_nettype none

package pq_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    localparam int num_ports       = 4;
    localparam int queues_per_port = 4;
    localparam int num_queues      = num_ports * queues_per_port;
    localparam int queue_depth     = 8;
    localparam int data_bytes      = 64;
    localparam int max_blen        = 1500;

    localparam int port_w       = $clog2(num_ports);
    localparam int prio_w       = $clog2(queues_per_port);
    localparam int queue_w      = $clog2(num_queues);
    localparam int slot_w       = $clog2(queue_depth);
    localparam int blen_w       = $clog2(max_blen + 1);
    localparam int word_bytes_w = $clog2(data_bytes + 1);

    typedef logic [queue_w-1:0]      queue_id_t;
    typedef logic [port_w-1:0]       port_id_t;
    typedef logic [blen_w-1:0]       blen_t;
    typedef logic [word_bytes_w-1:0] word_bytes_t;
    typedef logic [num_ports-1:0]    credit_vec_t;

    ////////////////////////////////////////////////////////////////////////////
    // Link payloads

    // Producer descriptor
    typedef struct packed {
        logic      valid;
        queue_id_t queue;
        blen_t     blen;
    } enq_desc_t;

    // Memory request, a write with zero length is a pop
    typedef struct packed {
        logic      valid;
        logic      write;
        queue_id_t queue;
        blen_t     blen;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        blen_t blen;
    } mem_rsp_t;

    typedef struct packed {
        logic      valid;
        queue_id_t queue;
    } deq_req_t;

    typedef struct packed {
        logic        valid;
        port_id_t    port;
        queue_id_t   queue;
        word_bytes_t bytes;
        logic        last;
    } egr_word_t;

    typedef enum logic [1:0] {
        idle,
        read,
        wait_rsp,
        send
    } deq_state_t;

    // Port number sits in the upper bits of a queue index
    function automatic port_id_t queue_port(input queue_id_t q);
        return q[queue_w-1 -: port_w];
    endfunction

endpackage

`default_nettype wire

// File: rtl/pq_sched.sv
/* Egress scheduler that tracks per-port word credits and picks the next queue
   by strict priority inside a port and round-robin between ports */

`default_nettype none

module pq_sched #(
    parameter int egr_credit_max = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [pq_pkg::num_queues-1:0] queue_empty,
    input  pq_pkg::credit_vec_t           egr_credit,
    input  pq_pkg::deq_req_t              word_sent,
    input  logic                          busy,
    output pq_pkg::deq_req_t              deq_req,
    output pq_pkg::credit_vec_t           credit_avail
);

    import pq_pkg::*;

    localparam int cnt_w = $clog2(egr_credit_max + 1);

    logic [cnt_w-1:0] credit_cnt [num_ports];
    credit_vec_t      credit_inc;
    credit_vec_t      credit_dec;
    credit_vec_t      port_elig;

    port_id_t         rr_ptr;
    port_id_t         cand;
    port_id_t         pick_port;
    logic [prio_w-1:0] pick_prio;
    logic             pick_found;

    ////////////////////////////////////////////////////////////////////////////
    // Credit counters

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            credit_inc[p] = egr_credit[p];
            credit_dec[p] = word_sent.valid && (queue_port(word_sent.queue) == port_id_t'(p));
        end
    end

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            credit_avail[p] = (credit_cnt[p] != '0);
        end
    end

    // Saturating counter where a grant and a spend in one cycle cancel out
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < num_ports; p++) begin
                credit_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (credit_inc[p] && !credit_dec[p] &&
                    credit_cnt[p] != cnt_w'(egr_credit_max)) begin
                    credit_cnt[p] <= credit_cnt[p] + 1'b1;
                end else if (credit_dec[p] && !credit_inc[p] && credit_cnt[p] != '0) begin
                    credit_cnt[p] <= credit_cnt[p] - 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pick

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            port_elig[p] = credit_avail[p] &&
                           !(&queue_empty[p*queues_per_port +: queues_per_port]);
        end
    end

    always_comb begin
        pick_found = 1'b0;
        pick_port  = rr_ptr;
        cand       = rr_ptr;
        // First eligible port at or after the pointer
        for (int i = 0; i < num_ports; i++) begin
            cand = rr_ptr + port_id_t'(i);
            if (!pick_found && port_elig[cand]) begin
                pick_found = 1'b1;
                pick_port  = cand;
            end
        end
        // Highest non-empty priority wins
        pick_prio = '0;
        for (int pr = 0; pr < queues_per_port; pr++) begin
            if (!queue_empty[{pick_port, prio_w'(pr)}]) begin
                pick_prio = prio_w'(pr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            deq_req <= '0;
            rr_ptr  <= '0;
        end else begin
            deq_req.valid <= 1'b0;
            // Engine goes busy only one cycle after the pulse
            if (!busy && !deq_req.valid && pick_found) begin
                deq_req.valid <= 1'b1;
                deq_req.queue <= {pick_port, pick_prio};
                rr_ptr        <= pick_port + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pq_top.sv
/* Packet queue scheduler top, ties the enqueue buffer, descriptor memory,
   scheduler and dequeue engine together */

`default_nettype none

module pq_top #(
    parameter int enq_fifo_depth = 4,
    parameter int egr_credit_max = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  pq_pkg::enq_desc_t   enq_in,
    output logic                enq_link_credit,
    output pq_pkg::deq_req_t    slot_free,
    input  pq_pkg::credit_vec_t egr_credit,
    output pq_pkg::egr_word_t   egr_out
);

    import pq_pkg::*;

    mem_req_t                enq_mem_req;
    logic                    enq_mem_grant;
    mem_req_t                deq_mem_req;
    logic                    deq_mem_grant;
    mem_rsp_t                mem_rsp;
    logic [num_queues-1:0]   queue_empty;
    deq_req_t                deq_req;
    deq_req_t                word_sent;
    logic                    busy;
    credit_vec_t             credit_avail;

    pq_enqueue #(
        .enq_fifo_depth  (enq_fifo_depth)
    ) i_pq_enqueue (
        .clk             (clk),
        .rst             (rst),
        .enq_in          (enq_in),
        .enq_mem_req     (enq_mem_req),
        .enq_mem_grant   (enq_mem_grant),
        .enq_link_credit (enq_link_credit)
    );

    pq_desc_mem i_pq_desc_mem (
        .clk             (clk),
        .rst             (rst),
        .enq_mem_req     (enq_mem_req),
        .enq_mem_grant   (enq_mem_grant),
        .deq_mem_req     (deq_mem_req),
        .deq_mem_grant   (deq_mem_grant),
        .mem_rsp         (mem_rsp),
        .queue_empty     (queue_empty),
        .slot_free       (slot_free)
    );

    pq_sched #(
        .egr_credit_max  (egr_credit_max)
    ) i_pq_sched (
        .clk             (clk),
        .rst             (rst),
        .queue_empty     (queue_empty),
        .egr_credit      (egr_credit),
        .word_sent       (word_sent),
        .busy            (busy),
        .deq_req         (deq_req),
        .credit_avail    (credit_avail)
    );

    pq_dequeue_engine i_pq_dequeue_engine (
        .clk             (clk),
        .rst             (rst),
        .deq_req         (deq_req),
        .busy            (busy),
        .deq_mem_req     (deq_mem_req),
        .deq_mem_grant   (deq_mem_grant),
        .mem_rsp         (mem_rsp),
        .credit_avail    (credit_avail),
        .word_sent       (word_sent),
        .egr_out         (egr_out)
    );

endmodule

`default_nettype wire
